// File: src/sdram_consts.svh
// timing in clk_in cycles for a >100 MHz controller clock; SD_INIT_WAIT is a sim value, silicon needs ~100 us
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// ----------------------------------------------------------------------
// chip timing
// ----------------------------------------------------------------------
`define SD_RASCAS_DELAY   3   // tRCD 20ns -> 3 clocks
`define SD_CAS_LATENCY    3   // CL3 needed above 100 MHz

// power-up sequence, counted down from SD_INIT_WAIT
`define SD_INIT_WAIT      25
`define SD_PRECHARGE_AT   20  // precharge all banks
`define SD_MODE_AT        10  // load mode register

// slot of the refresh, one past read capture
`define SD_SLOT_REFRESH   (`SD_RASCAS_DELAY + `SD_CAS_LATENCY + 2)
`define SD_MIN_CPU_CYCLE  10  // min clocks between as pulses

// ----------------------------------------------------------------------
// geometry
// ----------------------------------------------------------------------
`define SD_ROW_BITS       13  // also the address bus width
`define SD_COL_BITS       9
`define SD_BANK_BITS      2

`endif

// File: src/sdram_pkg.sv
// SDR SDRAM command and mode register views; command codes follow the JEDEC cs/ras/cas/we order
package sdram_pkg;

  // chip command, bit order cs ras cas we
  typedef enum logic [3:0] {
    CMD_INHIBIT         = 4'b1111,
    CMD_NOP             = 4'b0111,
    CMD_ACTIVE          = 4'b0011,
    CMD_READ            = 4'b0101,
    CMD_WRITE           = 4'b0100,
    CMD_BURST_TERMINATE = 4'b0110,
    CMD_PRECHARGE       = 4'b0010,
    CMD_AUTO_REFRESH    = 4'b0001,
    CMD_LOAD_MODE       = 4'b0000
  } sd_cmd_e;

  typedef struct packed {
    logic cs;   // chip select, low active
    logic ras;  // row strobe
    logic cas;  // column strobe
    logic we;   // write enable
  } sd_pin_t;

  // same 4 bits, encoded as a command or driven as pins
  typedef union packed {
    sd_cmd_e cmd;
    sd_pin_t pin;
  } sd_cmd_u;

  // mode register fields, A12..A0
  typedef struct packed {
    logic [2:0] reserved;     // must be 0
    logic       write_burst;  // 1 = single location writes
    logic [1:0] op_mode;      // 00 standard
    logic [2:0] cas_lat;
    logic       access_type;  // 0 sequential
    logic [2:0] burst_len;    // 000 = 1
  } sd_mode_t;

  typedef union packed {
    logic [12:0] word;  // as seen on the address bus
    sd_mode_t    f;
  } sd_mode_u;

endpackage

// File: src/cpu_bus_pkg.sv
// TMS99000 24-bit word address split onto one 16-bit SDRAM chip; bit 23 is not mapped
`include "sdram_consts.svh"

package cpu_bus_pkg;

  // ----------------------------------------------------------------------
  // cpu word address layout
  // ----------------------------------------------------------------------
  // row uses 12 of the 13 row bits, column is col_hi:col_lo
  typedef struct packed {
    logic                         unused;  // above 16M words
    logic                         col_hi;  // column bit 8
    logic [`SD_BANK_BITS-1:0]     bank;
    logic [`SD_ROW_BITS-2:0]      row;
    logic [`SD_COL_BITS-2:0]      col_lo;  // column bits 7..0
  } cpu_addr_t;

  typedef union packed {
    logic [23:0] word;  // flat, as the cpu drives it
    cpu_addr_t   f;
  } cpu_addr_u;

endpackage

// File: src/sdram_init_seq.sv
// power-up sequencer; counts only on clk_in and restarts on any reset, wait length set by SD_INIT_WAIT
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_init_seq
  import sdram_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     reset,
  output logic                     init_active,  // init owns the command bus
  output sd_cmd_u                  init_cmd,
  output logic [`SD_ROW_BITS-1:0]  init_addr,
  output logic [`SD_BANK_BITS-1:0] init_ba,
  output logic                     ready         // cycles allowed
);

  localparam int CNT_W = $clog2(`SD_INIT_WAIT + 1);

  logic [CNT_W-1:0] cnt;   // down-counter, 0 = done
  sd_mode_u         mode;  // mode word for LOAD MODE

  // ----------------------------------------------------------------------
  // wait counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (reset) begin
      cnt   <= CNT_W'(`SD_INIT_WAIT);
      ready <= 1'b0;
    end else begin
      if (cnt != '0)
        cnt <= cnt - 1'b1;
      ready <= (cnt == '0);  // one clock after count hits 0
    end
  end

  assign init_active = !ready;

  // mode: CL3, burst 1, sequential, single writes
  always_comb begin
    mode.f.reserved    = 3'b000;
    mode.f.write_burst = 1'b1;
    mode.f.op_mode     = 2'b00;
    mode.f.cas_lat     = 3'(`SD_CAS_LATENCY);
    mode.f.access_type = 1'b0;
    mode.f.burst_len   = 3'b000;
  end

  // ----------------------------------------------------------------------
  // command decode
  // ----------------------------------------------------------------------
  always_comb begin
    init_cmd.cmd = CMD_NOP;
    init_addr    = '0;
    init_ba      = '0;                     // all banks / mode reg
    if (!ready) begin
      if (cnt == CNT_W'(`SD_PRECHARGE_AT)) begin
        init_cmd.cmd   = CMD_PRECHARGE;
        init_addr[10]  = 1'b1;             // A10 = all banks
      end else if (cnt == CNT_W'(`SD_MODE_AT)) begin
        init_cmd.cmd = CMD_LOAD_MODE;
        init_addr    = mode.word;
      end
    end
  end

  // once up, only a reset may drop ready again
  a_ready_sticky : assert property (@(posedge clk_in)
    ready && !reset |=> ready)
    else $error("ready fell without reset");

endmodule

// File: src/sdram_cycle_seq.sv
// one fixed slot sequence per cpu machine cycle; as must be a one-clock pulse and cycles may not overlap
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_cycle_seq
  import sdram_pkg::*, cpu_bus_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic                     ready,    // init done
  input  logic                     as,       // start of cpu machine cycle
  input  logic                     csn,      // memory select, low active
  input  logic                     nwr,      // 0 = write
  input  logic [23:0]              addr,     // word address
  input  logic [15:0]              din,
  output sd_cmd_u                  cyc_cmd,
  output logic [`SD_ROW_BITS-1:0]  cyc_addr,
  output logic [`SD_BANK_BITS-1:0] cyc_ba,
  output logic [15:0]              wr_data,  // latched write data
  output logic                     data_oe,  // drive sd_data
  output logic                     capture   // load dout
);

  // ----------------------------------------------------------------------
  // slot map, each slot lands on the pins one clock later
  // ----------------------------------------------------------------------
  localparam logic [3:0] SLOT_ACTIVE  = 4'd0;
  localparam logic [3:0] SLOT_RW      = 4'(`SD_RASCAS_DELAY);
  localparam logic [3:0] SLOT_CAPTURE = 4'(`SD_RASCAS_DELAY + `SD_CAS_LATENCY + 1);
  localparam logic [3:0] SLOT_REFRESH = 4'(`SD_SLOT_REFRESH);
  localparam logic [3:0] SLOT_IDLE    = 4'hf;  // parked between cycles

  logic [3:0] slot;
  logic       acc_q;     // csn was low at as
  logic       wr_q;      // write cycle
  cpu_addr_u  addr_q;    // latched cpu address
  logic       start;

  assign start = as && ready;  // as ignored during init

  // ----------------------------------------------------------------------
  // slot counter and control latches
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (reset) begin
      slot  <= SLOT_IDLE;
      acc_q <= 1'b0;
      wr_q  <= 1'b0;
    end else if (start) begin
      slot  <= SLOT_ACTIVE;
      acc_q <= !csn;
      wr_q  <= !nwr;
    end else if (slot != SLOT_IDLE) begin
      slot <= slot + 1'b1;       // runs to idle and parks
    end
  end

  // payload, taken with the cycle
  always_ff @(posedge clk_in) begin
    if (start) begin
      addr_q.word <= addr;
      wr_data     <= din;
    end
  end

  // ----------------------------------------------------------------------
  // command and address decode
  // ----------------------------------------------------------------------
  always_comb begin
    cyc_cmd.cmd = CMD_NOP;                          // idle default
    if (acc_q && slot == SLOT_ACTIVE)
      cyc_cmd.cmd = CMD_ACTIVE;
    else if (acc_q && slot == SLOT_RW)
      cyc_cmd.cmd = wr_q ? CMD_WRITE : CMD_READ;
    else if (slot == SLOT_REFRESH)
      cyc_cmd.cmd = CMD_AUTO_REFRESH;               // every cycle, access or not
  end

  // row for ACTIVE, column with A10 set for auto-precharge
  always_comb begin
    if (slot == SLOT_RW)
      cyc_addr = {2'b00, 1'b1, 1'b0, addr_q.f.col_hi, addr_q.f.col_lo};
    else
      cyc_addr = {1'b0, addr_q.f.row};
  end

  assign cyc_ba = addr_q.f.bank;

  // write data out one clock before WRITE, off one clock after
  assign data_oe = acc_q && wr_q && (slot == SLOT_RW || slot == SLOT_RW + 4'd1);
  assign capture = acc_q && !wr_q && (slot == SLOT_CAPTURE);  // CL3 data at E8

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // cpu must leave room for the whole slot sequence
  a_as_spacing : assert property (@(posedge clk_in) disable iff (reset)
    start |=> (!as) [* (`SD_MIN_CPU_CYCLE - 1)])
    else $error("as closer than SD_MIN_CPU_CYCLE");

endmodule

// File: src/sdram_pins.sv
// pin layer; read capture is a plain clk_in register timed by slot, sd_clk is inverted clk_in, no byte masks
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_pins
  import sdram_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic                     init_active,
  input  sd_cmd_u                  init_cmd,
  input  logic [`SD_ROW_BITS-1:0]  init_addr,
  input  logic [`SD_BANK_BITS-1:0] init_ba,
  input  sd_cmd_u                  cyc_cmd,
  input  logic [`SD_ROW_BITS-1:0]  cyc_addr,
  input  logic [`SD_BANK_BITS-1:0] cyc_ba,
  input  logic [15:0]              wr_data,
  input  logic                     data_oe,
  input  logic                     capture,
  inout  wire  [15:0]              sd_data,   // shared data bus
  output logic [`SD_ROW_BITS-1:0]  sd_addr,
  output logic [`SD_BANK_BITS-1:0] sd_ba,
  output logic [1:0]               sd_dqm,
  output logic                     sd_cs,
  output logic                     sd_ras,
  output logic                     sd_cas,
  output logic                     sd_we,
  output logic                     sd_cke,
  output logic                     sd_clk,
  output logic [15:0]              dout
);

  sd_cmd_u cmd_q;  // command on the pins

  // ----------------------------------------------------------------------
  // command / address register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_in) begin
    if (reset)
      cmd_q.cmd <= CMD_INHIBIT;
    else
      cmd_q <= init_active ? init_cmd : cyc_cmd;
  end

  always_ff @(posedge clk_in) begin
    sd_addr <= init_active ? init_addr : cyc_addr;
    sd_ba   <= init_active ? init_ba : cyc_ba;
  end

  assign sd_cs  = cmd_q.pin.cs;
  assign sd_ras = cmd_q.pin.ras;
  assign sd_cas = cmd_q.pin.cas;
  assign sd_we  = cmd_q.pin.we;

  assign sd_dqm = 2'b00;     // full words only
  assign sd_cke = 1'b1;
  assign sd_clk = !clk_in;   // chip samples mid-cycle

  // tri-state bus and read capture
  assign sd_data = data_oe ? wr_data : 16'hzzzz;

  always_ff @(posedge clk_in) begin
    if (capture)
      dout <= sd_data;
  end

  // no write data may collide with a read burst from the chip
  a_no_drive_on_read : assert property (@(posedge clk_in) disable iff (reset)
    (cmd_q.cmd == CMD_READ) |-> (!data_oe) [* (`SD_CAS_LATENCY + 1)])
    else $error("sd_data driven while READ in flight");

endmodule

// File: src/tms_sdram_top.sv
// TMS99000 SDRAM controller top; clk_in must run at least 10x the cpu machine cycle rate
`timescale 1ns/1ps
`include "sdram_consts.svh"

module tms_sdram_top
  import sdram_pkg::*;
(
  input  logic                     clk_in,
  input  logic                     reset,
  // ----------------------------------------------------------------------
  // cpu side
  // ----------------------------------------------------------------------
  input  logic [15:0]              din,
  output logic [15:0]              dout,
  input  logic [23:0]              addr,
  input  logic                     csn,
  input  logic                     as,
  input  logic                     nwr,
  output logic                     ready,
  // ----------------------------------------------------------------------
  // chip side
  // ----------------------------------------------------------------------
  inout  wire  [15:0]              sd_data,
  output logic [`SD_ROW_BITS-1:0]  sd_addr,
  output logic [`SD_BANK_BITS-1:0] sd_ba,
  output logic [1:0]               sd_dqm,
  output logic                     sd_cs,
  output logic                     sd_ras,
  output logic                     sd_cas,
  output logic                     sd_we,
  output logic                     sd_cke,
  output logic                     sd_clk
);

  logic                     init_active;
  sd_cmd_u                  init_cmd;
  logic [`SD_ROW_BITS-1:0]  init_addr;
  logic [`SD_BANK_BITS-1:0] init_ba;
  sd_cmd_u                  cyc_cmd;
  logic [`SD_ROW_BITS-1:0]  cyc_addr;
  logic [`SD_BANK_BITS-1:0] cyc_ba;
  logic [15:0]              wr_data;
  logic                     data_oe;
  logic                     capture;

  sdram_init_seq u_init (
    .clk_in(clk_in), .reset(reset), .init_active(init_active), .init_cmd(init_cmd),
    .init_addr(init_addr), .init_ba(init_ba), .ready(ready)
  );

  sdram_cycle_seq u_cycle (
    .clk_in(clk_in), .reset(reset), .ready(ready), .as(as), .csn(csn), .nwr(nwr),
    .addr(addr), .din(din), .cyc_cmd(cyc_cmd), .cyc_addr(cyc_addr), .cyc_ba(cyc_ba),
    .wr_data(wr_data), .data_oe(data_oe), .capture(capture)
  );

  sdram_pins u_pins (
    .clk_in(clk_in), .reset(reset), .init_active(init_active), .init_cmd(init_cmd),
    .init_addr(init_addr), .init_ba(init_ba), .cyc_cmd(cyc_cmd), .cyc_addr(cyc_addr),
    .cyc_ba(cyc_ba), .wr_data(wr_data), .data_oe(data_oe), .capture(capture),
    .sd_data(sd_data), .sd_addr(sd_addr), .sd_ba(sd_ba), .sd_dqm(sd_dqm), .sd_cs(sd_cs),
    .sd_ras(sd_ras), .sd_cas(sd_cas), .sd_we(sd_we), .sd_cke(sd_cke), .sd_clk(sd_clk),
    .dout(dout)
  );

endmodule

// File: dv/sdram_model.sv
// behavioral single 16-bit SDR SDRAM; burst 1 only, no refresh interval or tRP timing, array survives dut reset
`timescale 1ns/1ps
`include "sdram_consts.svh"

module sdram_model
  import sdram_pkg::*;
(
  input  logic                     clk,  // sd_clk, mid-cycle of clk_in
  input  logic [`SD_ROW_BITS-1:0]  a,
  input  logic [`SD_BANK_BITS-1:0] ba,
  input  logic                     cs,
  input  logic                     ras,
  input  logic                     cas,
  input  logic                     we,
  inout  wire  [15:0]              dq
);

  logic [15:0]              mem [logic [23:0]];  // sparse, bank:row:col
  sd_cmd_u                  cmd;
  sd_mode_u                 last_mode;           // decoded by the testbench too
  logic                     pre_ok = 1'b0;       // PRECHARGE ALL seen
  logic                     mode_ok = 1'b0;      // mode loaded after it
  logic                     act_open = 1'b0;     // row waiting for READ/WRITE
  logic [`SD_BANK_BITS-1:0] act_bank;
  logic [`SD_ROW_BITS-1:0]  act_row;
  logic [23:0]              key;
  logic [15:0]              rd_word;
  logic [15:0]              dq_out;
  logic                     dq_oe = 1'b0;
  int                       tick = 0;            // chip clocks
  int                       act_tick = 0;
  int                       rd_wait = 0;         // clocks left to read data
  int                       pre_all_cnt = 0;
  int                       mode_cnt = 0;
  int                       active_cnt = 0;
  int                       rw_cnt = 0;
  int                       refresh_cnt = 0;
  int                       err_cnt = 0;

  // unwritten words read back a pattern of the full address
  function automatic logic [15:0] fill_word(input logic [23:0] k);
    return k[15:0] ^ {k[23:16], k[23:16]};
  endfunction

  task automatic protocol_check(input logic ok, input string what);
    assert (ok) else begin
      $display("sdram model at %0t: %s", $time, what);
      err_cnt++;
    end
  endtask

  assign cmd = {cs, ras, cas, we};
  assign dq  = dq_oe ? dq_out : 16'hzzzz;

  // ----------------------------------------------------------------------
  // command decode, one command per chip clock
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    tick = tick + 1;
    dq_oe <= 1'b0;
    if (rd_wait == 1) begin      // CL reached, data valid for one clock
      dq_oe  <= 1'b1;
      dq_out <= rd_word;
    end
    if (rd_wait != 0)
      rd_wait = rd_wait - 1;
    case (cmd.cmd)
      CMD_PRECHARGE: begin
        if (a[10]) begin         // all banks, starts a new init
          pre_ok   = 1'b1;
          mode_ok  = 1'b0;
          act_open = 1'b0;
          pre_all_cnt++;
        end
      end
      CMD_LOAD_MODE: begin
        last_mode.word = a;
        protocol_check(pre_ok && !act_open, "LOAD MODE without PRECHARGE ALL first");
        protocol_check(last_mode.f.cas_lat == 3'(`SD_CAS_LATENCY) &&
                       last_mode.f.burst_len == 3'b000 && last_mode.f.write_burst,
                       "mode register fields are not CL3, burst 1, single write");
        mode_ok = 1'b1;
        mode_cnt++;
      end
      CMD_ACTIVE: begin
        protocol_check(mode_ok, "ACTIVE before the mode register was loaded");
        protocol_check(!act_open, "ACTIVE while another row is still open");
        act_open = 1'b1;
        act_bank = ba;
        act_row  = a;
        act_tick = tick;
        active_cnt++;
      end
      CMD_READ, CMD_WRITE: begin
        protocol_check(act_open && ba == act_bank, "READ/WRITE bank differs from ACTIVE");
        protocol_check(tick - act_tick >= `SD_RASCAS_DELAY, "ACTIVE to READ/WRITE too close");
        protocol_check(a[10], "READ/WRITE without auto-precharge");
        key = {ba, act_row, a[8:0]};
        if (cmd.cmd == CMD_WRITE) begin
          mem[key] = dq;
        end else begin
          rd_word = mem.exists(key) ? mem[key] : fill_word(key);
          rd_wait = `SD_CAS_LATENCY;
        end
        act_open = 1'b0;         // auto-precharge closes the row
        rw_cnt++;
      end
      CMD_AUTO_REFRESH: begin
        protocol_check(mode_ok && !act_open, "AUTO REFRESH with a row open or before init");
        refresh_cnt++;
      end
      default: ;                 // NOP, INHIBIT, unknown at power-up
    endcase
  end

endmodule

// File: dv/tb_tms_sdram.sv
// testbench for tms_sdram_top; one cpu cycle at a time, the model's refresh count marks a cycle's end
`timescale 1ns/1ps
`include "sdram_consts.svh"

module tb_tms_sdram
  import cpu_bus_pkg::*;
();

  localparam int WAIT_LIMIT = 200;  // clocks for any single wait
  localparam int N_RAND     = 12;

  logic                     clk_in;
  logic                     reset;
  logic [15:0]              din;
  logic [15:0]              dout;
  logic [23:0]              addr;
  logic                     csn;
  logic                     as;
  logic                     nwr;
  logic                     ready;
  wire  [15:0]              sd_data;
  logic [`SD_ROW_BITS-1:0]  sd_addr;
  logic [`SD_BANK_BITS-1:0] sd_ba;
  logic [1:0]               sd_dqm;
  logic                     sd_cs;
  logic                     sd_ras;
  logic                     sd_cas;
  logic                     sd_we;
  logic                     sd_cke;
  logic                     sd_clk;
  integer                   seed;
  logic [15:0]              sb [logic [23:0]];  // last word written per address
  logic [23:0]              used_addr [$];
  int                       last_ref;           // refreshes seen so far

  tms_sdram_top dut (.*);

  sdram_model model (
    .clk(sd_clk), .a(sd_addr), .ba(sd_ba), .cs(sd_cs), .ras(sd_ras), .cas(sd_cas),
    .we(sd_we), .dq(sd_data)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_word(input string sig, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp)
      else fail_run($sformatf("ERR %0t %s expected %h got %h", $time, sig, exp, got));
  endtask

  task automatic check_count(input string sig, input int exp, input int got);
    assert (got == exp)
      else fail_run($sformatf("ERR %0t %s expected %0d got %0d", $time, sig, exp, got));
  endtask

  a_model_clean : assert property (@(posedge clk_in) model.err_cnt == 0)
    else fail_run($sformatf("ERR %0t model.err_cnt expected 0 got %0d", $time, model.err_cnt));

  a_ready_after_mode : assert property (@(posedge clk_in) $rose(ready) |-> model.mode_ok)
    else fail_run("ready rose before PRECHARGE ALL and LOAD MODE were both seen");

  a_pins_fixed : assert property (@(posedge clk_in) disable iff (reset)
    sd_cke && sd_dqm == 2'b00)
    else fail_run("sd_cke low or sd_dqm not zero after reset");

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  function automatic logic [23:0] rand_addr();
    cpu_addr_u x;
    x.word = 24'($random(seed));
    x.f.unused = 1'b0;              // bit 23 aliases
    return x.word;
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) @(posedge clk_in);
    #2;
    reset = 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1) begin
      if (n == WAIT_LIMIT)
        fail_run("timeout waiting for ready to rise after reset");
      @(posedge clk_in);
      #2;
      n++;
    end
  endtask

  // one as pulse, returns once the cycle's refresh reached the chip
  task automatic cpu_cycle(input logic [23:0] a, input logic wr, input logic sel,
                           input logic [15:0] d);
    int act0;
    int rw0;
    int n;
    act0 = model.active_cnt;
    rw0  = model.rw_cnt;
    check_count("model.refresh_cnt", last_ref, model.refresh_cnt);  // none between cycles
    as   = 1'b1;
    csn  = !sel;
    nwr  = !wr;
    addr = a;
    din  = d;
    @(posedge clk_in);
    #2;
    as  = 1'b0;
    csn = 1'b1;
    nwr = 1'b1;
    n = 0;
    while (model.refresh_cnt == last_ref) begin
      if (n == WAIT_LIMIT)
        fail_run("timeout waiting for the AUTO REFRESH of a cpu cycle");
      @(posedge clk_in);
      #2;
      n++;
    end
    last_ref++;
    check_count("model.active_cnt", act0 + (sel ? 1 : 0), model.active_cnt);
    check_count("model.rw_cnt", rw0 + (sel ? 1 : 0), model.rw_cnt);
  endtask

  task automatic write_word(input logic [23:0] a, input logic [15:0] d);
    cpu_cycle(a, 1'b1, 1'b1, d);
    sb[a] = d;
  endtask

  task automatic read_check(input logic [23:0] a);
    cpu_cycle(a, 1'b0, 1'b1, 16'h0000);
    check_word("dout", sb[a], dout);
  endtask

  initial begin
    cpu_addr_u   base;
    cpu_addr_u   alt;
    logic [15:0] held;
    int          pre0;
    int          mode0;
    seed  = 99451;
    reset = 1'b1;
    as    = 1'b0;
    csn   = 1'b1;
    nwr   = 1'b1;
    addr  = '0;
    din   = '0;
    apply_reset();
    // power-up order and mode fields
    wait_ready();
    check_count("model.pre_all_cnt", 1, model.pre_all_cnt);
    check_count("model.mode_cnt", 1, model.mode_cnt);
    check_count("model.active_cnt", 0, model.active_cnt);
    check_count("mode cas_lat", `SD_CAS_LATENCY, int'(model.last_mode.f.cas_lat));
    check_count("mode burst_len", 0, int'(model.last_mode.f.burst_len));
    check_count("mode write_burst", 1, int'(model.last_mode.f.write_burst));
    last_ref = model.refresh_cnt;
    for (int i = 0; i < N_RAND; i++) begin
      used_addr.push_back(rand_addr());
      write_word(used_addr[i], 16'($random(seed)));
    end
    // neighbours differing only in bank, row or col_hi
    base.word = rand_addr();
    for (int k = 0; k < 4; k++) begin
      alt = base;
      if (k == 1)
        alt.f.bank = ~base.f.bank;
      if (k == 2)
        alt.f.row[0] = ~base.f.row[0];
      if (k == 3)
        alt.f.col_hi = ~base.f.col_hi;
      used_addr.push_back(alt.word);
      write_word(alt.word, {4'(k), 12'($random(seed))});  // distinct by k
    end
    foreach (used_addr[i])
      read_check(used_addr[i]);
    // deselected cycles, refresh only, dout and memory untouched
    held = dout;
    cpu_cycle(used_addr[0], 1'b0, 1'b0, 16'h0000);
    check_word("dout", held, dout);
    cpu_cycle(used_addr[0], 1'b1, 1'b0, ~sb[used_addr[0]]);
    check_word("dout", held, dout);
    read_check(used_addr[0]);
    // reset right after ACTIVE of a read
    pre0  = model.pre_all_cnt;
    mode0 = model.mode_cnt;
    as    = 1'b1;
    csn   = 1'b0;
    addr  = used_addr[1];
    @(posedge clk_in);
    #2;
    as  = 1'b0;
    csn = 1'b1;
    @(posedge clk_in);
    #2;
    apply_reset();
    check_count("ready", 0, int'(ready));
    wait_ready();
    check_count("model.pre_all_cnt", pre0 + 1, model.pre_all_cnt);
    check_count("model.mode_cnt", mode0 + 1, model.mode_cnt);
    last_ref = model.refresh_cnt;
    foreach (used_addr[i])
      read_check(used_addr[i]);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: tms_sdram.f
+incdir+src
src/sdram_pkg.sv
src/cpu_bus_pkg.sv
src/sdram_init_seq.sv
src/sdram_cycle_seq.sv
src/sdram_pins.sv
src/tms_sdram_top.sv
dv/sdram_model.sv
dv/tb_tms_sdram.sv

// File: run_sim.sh
#!/bin/sh
# build the tms_sdram testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_tms_sdram -Mdir obj_dir -f tms_sdram.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_tms_sdram
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
